/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  // ====================
  // Cache geometry
  // ====================

  // Address and word width
  localparam int XLEN           = 32;
  // One line holds four words
  localparam int LINE_BITS      = 128;
  localparam int WORDS_PER_LINE = LINE_BITS / XLEN;
  localparam int NUM_WAY        = 4;
  localparam int NUM_SET        = 16;
  // Address split is tag | index | word offset | byte in word
  localparam int IDX_W          = 4;
  localparam int WOFF_W         = 2;
  localparam int BOFF_W         = 4;
  localparam int TAG_W          = XLEN - IDX_W - BOFF_W;
  // Tree bits per set, root in bit 0
  localparam int NODE_W         = NUM_WAY - 1;

  // ====================
  // Port types
  // ====================

  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [NUM_WAY-1:0]   way_vec_t;

  // One tag RAM entry
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  // CPU side, one word per access, rw high for a store
  typedef struct packed {
    logic            valid;
    logic            rw;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
  } cpu_res_t;

  // Lower memory side, whole lines at line-aligned addresses
  typedef struct packed {
    logic            valid;
    logic            rw;
    logic [XLEN-1:0] addr;
    line_t           wline;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    line_t rline;
  } mem_res_t;

endpackage

`default_nettype wire

/* design/dcache_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ram
  import dcache_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  wire logic             clk_i,
  input  wire logic [IDX_W-1:0] idx_i,
  input  wire logic             we_i,
  input  wire payload_t         wdata_i,
  output payload_t              rdata_o
);

  // One entry per set
  payload_t mem_q [NUM_SET];

  // Read-first port, the write shows up on the next read
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[idx_i] <= wdata_i;
    end
    rdata_o <= mem_q[idx_i];
  end

endmodule

`default_nettype wire

/* design/dcache_plru.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_plru
  import dcache_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic [IDX_W-1:0] idx_i,
  input  wire logic             touch_i,
  input  wire way_vec_t         touch_way_i,
  input  wire logic             clear_i,
  input  wire way_vec_t         valid_vec_i,
  output way_vec_t              victim_o
);

  // Node 0 is the root, 0 points left; node 1 picks in ways 0/1, node 2 in ways 2/3
  logic [NODE_W-1:0] node_mem [NUM_SET];
  logic [NODE_W-1:0] node_q;
  logic [NODE_W-1:0] node_upd;
  way_vec_t          tree_way;
  way_vec_t          free_way;

  // Node storage, read registered to line up with the tag RAM output
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      node_mem[idx_i] <= '0;
    end else if (touch_i) begin
      node_mem[idx_i] <= node_upd;
    end
    if (!rst_ni) begin
      node_q <= '0;
    end else begin
      node_q <= node_mem[idx_i];
    end
  end

  // Point every node on the path away from the touched way
  always_comb begin
    node_upd = node_mem[idx_i];
    if (touch_way_i[0] || touch_way_i[1]) begin
      node_upd[0] = 1'b1;
      node_upd[1] = touch_way_i[0];
    end else begin
      node_upd[0] = 1'b0;
      node_upd[2] = touch_way_i[2];
    end
  end

  always_comb begin
    tree_way = '0;
    tree_way[{node_q[0], node_q[0] ? node_q[2] : node_q[1]}] = 1'b1;
    // Lowest clear bit of the valid vector
    free_way = ~valid_vec_i & (valid_vec_i + 1'b1);
    victim_o = (|free_way) ? free_way : tree_way;
  end

  // Storage is only defined once the sweep has passed, one read cycle later
  a_victim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !clear_i && !$past(clear_i) |-> $onehot(victim_o));

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire cpu_req_t                   cpu_req_i,
  output logic                            cpu_ready_o,
  output cpu_res_t                        cpu_res_o,
  output mem_req_t                        mem_req_o,
  input  wire mem_res_t                   mem_res_i,
  input  wire tag_entry_t [NUM_WAY-1:0]   tag_rd_i,
  input  wire line_t [NUM_WAY-1:0]        line_rd_i,
  output logic [IDX_W-1:0]                tag_idx_o,
  output way_vec_t                        tag_we_o,
  output tag_entry_t                      tag_wdata_o,
  output logic [IDX_W-1:0]                line_idx_o,
  output way_vec_t                        line_we_o,
  output line_t                           line_wdata_o,
  output logic [IDX_W-1:0]                plru_idx_o,
  output logic                            plru_touch_o,
  output way_vec_t                        plru_touch_way_o,
  output logic                            plru_clear_o,
  output way_vec_t                        valid_vec_o,
  input  wire way_vec_t                   victim_i
);

  typedef enum logic [2:0] {
    ST_SWEEP, ST_IDLE, ST_COMPARE, ST_WRITEBACK, ST_REFILL, ST_RESPOND
  } state_e;

  state_e            state_q, state_d;
  logic [IDX_W-1:0]  sweep_cnt_q;
  logic [IDX_W-1:0]  ram_idx;
  cpu_req_t          req_q;
  way_vec_t          victim_q;
  mem_req_t          mem_req_q, mem_req_d;
  logic [XLEN-1:0]   rdata_q, rdata_d;
  logic              rdata_we;
  way_vec_t          dirty_q [NUM_SET];
  way_vec_t          dirty_we;
  logic              dirty_val;
  // Request fields and lookup results
  logic [IDX_W-1:0]  req_idx;
  logic [TAG_W-1:0]  req_tag;
  logic [WOFF_W-1:0] req_woff;
  way_vec_t          hit_vec;
  logic              hit;
  line_t             hit_line;
  logic [TAG_W-1:0]  victim_tag;
  line_t             victim_line;
  logic              victim_dirty;

  function automatic line_t put_word(line_t line, logic [WOFF_W-1:0] woff,
                                     logic [XLEN-1:0] word);
    line_t res;
    res = line;
    res[woff*XLEN +: XLEN] = word;
    return res;
  endfunction

  assign req_idx  = req_q.addr[BOFF_W +: IDX_W];
  assign req_tag  = req_q.addr[XLEN-1 -: TAG_W];
  assign req_woff = req_q.addr[BOFF_W-WOFF_W +: WOFF_W];

  // ====================
  // Lookup
  // ====================

  always_comb begin
    hit_line     = '0;
    victim_tag   = '0;
    victim_line  = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      valid_vec_o[w] = tag_rd_i[w].valid;
      hit_vec[w]     = tag_rd_i[w].valid && (tag_rd_i[w].tag == req_tag);
      if (hit_vec[w]) hit_line = line_rd_i[w];
      if (victim_i[w]) begin
        victim_tag  = tag_rd_i[w].tag;
        victim_line = line_rd_i[w];
      end
    end
    hit          = |hit_vec;
    // Only a valid line with its dirty bit set goes back to memory
    victim_dirty = |(victim_i & valid_vec_o & dirty_q[req_idx]);
  end

  // Sweep walks the sets, idle looks up the incoming request, else the held one
  always_comb begin
    if (state_q == ST_SWEEP)     ram_idx = sweep_cnt_q;
    else if (state_q == ST_IDLE) ram_idx = cpu_req_i.addr[BOFF_W +: IDX_W];
    else                         ram_idx = req_idx;
  end

  assign tag_idx_o  = ram_idx;
  assign line_idx_o = ram_idx;
  assign plru_idx_o = ram_idx;

  // ====================
  // State machine
  // ====================

  always_comb begin
    state_d          = state_q;
    mem_req_d        = mem_req_q;
    tag_we_o         = '0;
    tag_wdata_o      = '{valid: 1'b1, tag: req_tag};
    line_we_o        = '0;
    line_wdata_o     = put_word(hit_line, req_woff, req_q.wdata);
    plru_touch_o     = 1'b0;
    plru_touch_way_o = hit_vec;
    plru_clear_o     = 1'b0;
    dirty_we         = '0;
    dirty_val        = 1'b1;
    rdata_we         = 1'b0;
    rdata_d          = req_q.rw ? '0 : hit_line[req_woff*XLEN +: XLEN];
    unique case (state_q)
      ST_SWEEP: begin
        // Invalidate all ways of one set per cycle
        tag_we_o     = '1;
        tag_wdata_o  = '0;
        plru_clear_o = 1'b1;
        if (sweep_cnt_q == IDX_W'(NUM_SET - 1)) state_d = ST_IDLE;
      end
      ST_IDLE: begin
        if (cpu_req_i.valid) state_d = ST_COMPARE;
      end
      ST_COMPARE: begin
        if (hit) begin
          // Store hit merges the word in place and marks the line dirty
          line_we_o    = req_q.rw ? hit_vec : '0;
          dirty_we     = req_q.rw ? hit_vec : '0;
          plru_touch_o = 1'b1;
          rdata_we     = 1'b1;
          state_d      = ST_RESPOND;
        end else if (victim_dirty) begin
          mem_req_d = '{valid: 1'b1, rw: 1'b1,
                        addr: {victim_tag, req_idx, BOFF_W'(0)}, wline: victim_line};
          state_d   = ST_WRITEBACK;
        end else begin
          mem_req_d = '{valid: 1'b1, rw: 1'b0,
                        addr: {req_q.addr[XLEN-1:BOFF_W], BOFF_W'(0)}, wline: '0};
          state_d   = ST_REFILL;
        end
      end
      ST_WRITEBACK: begin
        // Victim written, now fetch the requested line
        if (mem_res_i.valid) begin
          mem_req_d = '{valid: 1'b1, rw: 1'b0,
                        addr: {req_q.addr[XLEN-1:BOFF_W], BOFF_W'(0)}, wline: '0};
          state_d   = ST_REFILL;
        end
      end
      ST_REFILL: begin
        tag_wdata_o      = '{valid: 1'b1, tag: req_tag};
        line_wdata_o     = req_q.rw ? put_word(mem_res_i.rline, req_woff, req_q.wdata)
                                    : mem_res_i.rline;
        plru_touch_way_o = victim_q;
        dirty_val        = req_q.rw;
        rdata_d          = req_q.rw ? '0 : mem_res_i.rline[req_woff*XLEN +: XLEN];
        if (mem_res_i.valid) begin
          tag_we_o        = victim_q;
          line_we_o       = victim_q;
          dirty_we        = victim_q;
          plru_touch_o    = 1'b1;
          rdata_we        = 1'b1;
          mem_req_d.valid = 1'b0;
          state_d         = ST_RESPOND;
        end
      end
      ST_RESPOND: state_d = ST_IDLE;
      default:    state_d = ST_SWEEP;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q         <= ST_SWEEP;
      sweep_cnt_q     <= '0;
      mem_req_q.valid <= 1'b0;
    end else begin
      state_q     <= state_d;
      sweep_cnt_q <= (state_q == ST_SWEEP) ? sweep_cnt_q + 1'b1 : '0;
      mem_req_q   <= mem_req_d;
    end
  end

  // Request, victim and read word
  always_ff @(posedge clk_i) begin
    if (cpu_ready_o && cpu_req_i.valid) req_q <= cpu_req_i;
    if (state_q == ST_COMPARE) victim_q <= victim_i;
    if (rdata_we) rdata_q <= rdata_d;
  end

  // Dirty bits, cleared set by set in the sweep
  always_ff @(posedge clk_i) begin
    if (state_q == ST_SWEEP) begin
      dirty_q[sweep_cnt_q] <= '0;
    end else begin
      for (int w = 0; w < NUM_WAY; w++) begin
        if (dirty_we[w]) dirty_q[req_idx][w] <= dirty_val;
      end
    end
  end

  assign cpu_ready_o = (state_q == ST_IDLE);
  assign cpu_res_o   = '{valid: (state_q == ST_RESPOND), rdata: rdata_q};
  assign mem_req_o   = mem_req_q;

  // Outstanding memory request holds until memory answers
  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.valid && !mem_res_i.valid |=> $stable(mem_req_o));

  // Nothing leaves the cache while the sets are being invalidated
  a_sweep_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ST_SWEEP |-> !cpu_res_o.valid && !mem_req_o.valid);

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire cpu_req_t cpu_req_i,
  output logic          cpu_ready_o,
  output cpu_res_t      cpu_res_o,
  output mem_req_t      mem_req_o,
  input  wire mem_res_t mem_res_i
);

  // Per-way read data
  wire tag_entry_t [NUM_WAY-1:0] tag_rd;
  wire line_t [NUM_WAY-1:0]      line_rd;

  // Shared write and index lines from the controller
  logic [IDX_W-1:0] tag_idx;
  way_vec_t         tag_we;
  tag_entry_t       tag_wdata;
  logic [IDX_W-1:0] line_idx;
  way_vec_t         line_we;
  line_t            line_wdata;

  // Replacement unit hookup
  logic [IDX_W-1:0] plru_idx;
  logic             plru_touch;
  way_vec_t         plru_touch_way;
  logic             plru_clear;
  way_vec_t         valid_vec;
  way_vec_t         victim;

  // ====================
  // Tag and line RAMs
  // ====================

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    dcache_ram #(
      .payload_t(tag_entry_t)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .idx_i  (tag_idx),
      .we_i   (tag_we[w]),
      .wdata_i(tag_wdata),
      .rdata_o(tag_rd[w])
    );

    dcache_ram #(
      .payload_t(line_t)
    ) u_line_ram (
      .clk_i  (clk_i),
      .idx_i  (line_idx),
      .we_i   (line_we[w]),
      .wdata_i(line_wdata),
      .rdata_o(line_rd[w])
    );
  end

  dcache_plru u_plru (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .idx_i      (plru_idx),
    .touch_i    (plru_touch),
    .touch_way_i(plru_touch_way),
    .clear_i    (plru_clear),
    .valid_vec_i(valid_vec),
    .victim_o   (victim)
  );

  dcache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cpu_req_i       (cpu_req_i),
    .cpu_ready_o     (cpu_ready_o),
    .cpu_res_o       (cpu_res_o),
    .mem_req_o       (mem_req_o),
    .mem_res_i       (mem_res_i),
    .tag_rd_i        (tag_rd),
    .line_rd_i       (line_rd),
    .tag_idx_o       (tag_idx),
    .tag_we_o        (tag_we),
    .tag_wdata_o     (tag_wdata),
    .line_idx_o      (line_idx),
    .line_we_o       (line_we),
    .line_wdata_o    (line_wdata),
    .plru_idx_o      (plru_idx),
    .plru_touch_o    (plru_touch),
    .plru_touch_way_o(plru_touch_way),
    .plru_clear_o    (plru_clear),
    .valid_vec_o     (valid_vec),
    .victim_i        (victim)
  );

endmodule

`default_nettype wire

/* verification/dcache_tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb_clock (
  output logic clk_o
);

  // Free-running clock, 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* verification/dcache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_checker
  import dcache_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire cpu_req_t cpu_req_i,
  input  wire logic     cpu_ready_i,
  input  wire cpu_res_t cpu_res_i,
  input  wire mem_req_t mem_req_i,
  input  wire mem_res_t mem_res_i,
  output int            errors_o,
  output int            wb_count_o
);

  // Reference word memory holds only words written by accepted stores
  logic [XLEN-1:0] ref_mem [logic [XLEN-1:0]];
  cpu_req_t        pend;
  logic            pend_valid;
  logic            refill_seen;
  logic            refill_due;
  logic            ready_seen;
  int              sweep_cycles;

  // Same fill pattern as the lower-memory model
  function automatic logic [XLEN-1:0] init_word(logic [XLEN-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_e719;
  endfunction

  function automatic logic [XLEN-1:0] expected_word(logic [XLEN-1:0] addr);
    logic [XLEN-1:0] key;
    key = {addr[XLEN-1:2], 2'b00};
    if (ref_mem.exists(key)) return ref_mem[key];
    return init_word(key);
  endfunction

  always @(posedge clk_i) begin : watch
    logic [XLEN-1:0] line_base;
    logic [XLEN-1:0] exp;
    if (!rst_ni) begin
      errors_o     = 0;
      wb_count_o   = 0;
      pend_valid   = 1'b0;
      refill_seen  = 1'b0;
      refill_due   = 1'b0;
      ready_seen   = 1'b0;
      sweep_cycles = 0;
    end else begin
      // ====================
      // Reset sweep
      // ====================
      if (!ready_seen) begin
        if (mem_req_i.valid) begin
          $display("memory request issued during the reset sweep at %0t", $time);
          errors_o++;
        end
        if (cpu_ready_i) begin
          ready_seen = 1'b1;
          if (sweep_cycles != NUM_SET) begin
            $display("mismatch at %0t: ready rose after %0d sweep cycles expected %0d",
                     $time, sweep_cycles, NUM_SET);
            errors_o++;
          end
        end else begin
          sweep_cycles++;
        end
      end
      // ====================
      // Memory traffic
      // ====================
      // Checked in the cycle that memory completes it
      if (mem_req_i.valid && mem_res_i.valid) begin
        line_base = pend.addr & ~32'(LINE_BITS / 8 - 1);
        if (!pend_valid) begin
          $display("memory request at %0t with no CPU request in flight", $time);
          errors_o++;
        end else if (mem_req_i.rw) begin
          wb_count_o++;
          if (refill_seen) begin
            $display("writeback at %0t came after the refill of the same miss", $time);
            errors_o++;
          end
          // Victim is another line of the same set and sits on a line boundary
          if (mem_req_i.addr == line_base || mem_req_i.addr[BOFF_W-1:0] != '0 ||
              mem_req_i.addr[BOFF_W +: IDX_W] != pend.addr[BOFF_W +: IDX_W]) begin
            $display("writeback at %0t to bad address %08h", $time, mem_req_i.addr);
            errors_o++;
          end
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp = expected_word(mem_req_i.addr + 32'(w * 4));
            if (mem_req_i.wline[w*XLEN +: XLEN] != exp) begin
              $display("mismatch at %0t: writeback word %08h got %08h expected %08h", $time,
                       mem_req_i.addr + 32'(w * 4), mem_req_i.wline[w*XLEN +: XLEN], exp);
              errors_o++;
            end
          end
          refill_due = 1'b1;
        end else begin
          if (mem_req_i.addr != line_base) begin
            $display("mismatch at %0t: refill read %08h expected %08h", $time,
                     mem_req_i.addr, line_base);
            errors_o++;
          end
          refill_seen = 1'b1;
          refill_due  = 1'b0;
        end
      end
      // ====================
      // CPU port
      // ====================
      if (cpu_res_i.valid) begin
        if (!pend_valid) begin
          $display("response at %0t without an accepted request", $time);
          errors_o++;
        end else begin
          // Stores answer with zero
          exp = pend.rw ? '0 : expected_word(pend.addr);
          if (cpu_res_i.rdata != exp) begin
            $display("mismatch at %0t: %s %08h got %08h expected %08h", $time,
                     pend.rw ? "store" : "load", pend.addr, cpu_res_i.rdata, exp);
            errors_o++;
          end
          if (refill_due) begin
            $display("response at %0t after a writeback but no refill", $time);
            errors_o++;
          end
        end
        pend_valid = 1'b0;
      end
      if (cpu_req_i.valid && cpu_ready_i) begin
        if (pend_valid) begin
          $display("request accepted at %0t before the previous one answered", $time);
          errors_o++;
        end
        pend        = cpu_req_i;
        pend_valid  = 1'b1;
        refill_seen = 1'b0;
        refill_due  = 1'b0;
        if (cpu_req_i.rw) ref_mem[{cpu_req_i.addr[XLEN-1:2], 2'b00}] = cpu_req_i.wdata;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();

  localparam logic [31:0] SEED      = 32'h9985_a019;
  localparam logic [31:0] BASE_ADDR = 32'h0004_0000;
  localparam int N_COLD  = 8;
  localparam int N_PAIR  = 4;
  localparam int N_EVICT = 5;
  localparam int N_RAND  = 400;
  localparam int N_OPS   = N_COLD + 2 * N_PAIR + 2 * N_EVICT + N_RAND;
  // Reset, sweep, then 200 cycles per access
  localparam int MAX_CYCLES = 3 + NUM_SET + 200 * N_OPS;

  logic     clk;
  logic     rst_n;
  cpu_req_t cpu_req;
  logic     cpu_ready;
  cpu_res_t cpu_res;
  mem_req_t mem_req;
  mem_res_t mem_res = '0;

  int errors;
  int wb_count;
  int tb_errors;
  int errors_before;
  int failed_tests;
  int cycle_cnt;

  // Separate LCG streams for stimulus and memory delays
  logic [31:0] stim_state;
  logic [31:0] mem_state;
  // Lower memory, keyed by line address
  line_t       mem_lines [logic [31:0]];
  int          mem_phase;
  int          mem_delay;

  dcache_tb_clock u_clock (
    .clk_o(clk)
  );

  dcache_top DUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cpu_req_i  (cpu_req),
    .cpu_ready_o(cpu_ready),
    .cpu_res_o  (cpu_res),
    .mem_req_o  (mem_req),
    .mem_res_i  (mem_res)
  );

  dcache_checker u_checker (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cpu_req_i  (cpu_req),
    .cpu_ready_i(cpu_ready),
    .cpu_res_i  (cpu_res),
    .mem_req_i  (mem_req),
    .mem_res_i  (mem_res),
    .errors_o   (errors),
    .wb_count_o (wb_count)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] init_word(logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_e719;
  endfunction

  function automatic line_t fill_line(logic [31:0] line_addr);
    line_t line;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      line[w*XLEN +: XLEN] = init_word(line_addr + 32'(w * 4));
    end
    return line;
  endfunction

  // Line n of the window sits in set n % 8 with tag n / 8
  function automatic logic [31:0] window_addr(int line_no, int woff);
    return BASE_ADDR + 32'(line_no / 8) * 32'h100 + 32'(line_no % 8) * 32'h10
           + 32'(woff) * 32'd4;
  endfunction

  // Halves swapped so the low bits come from the better LCG bits
  task automatic draw(output logic [31:0] value);
    stim_state = lcg_next(stim_state);
    value      = {stim_state[15:0], stim_state[31:16]};
  endtask

  // One access, waits for acceptance and then for the response
  task automatic access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata);
    cpu_req <= '{valid: 1'b1, rw: rw, addr: addr, wdata: wdata};
    @(posedge clk);
    while (!cpu_ready) @(posedge clk);
    cpu_req <= '0;
    @(posedge clk);
    while (!cpu_res.valid) @(posedge clk);
  endtask

  // Counts are read mid-cycle, away from the checker's edge
  task automatic report_test(input int num, input string name);
    int new_errors;
    @(negedge clk);
    new_errors    = errors + tb_errors - errors_before;
    errors_before = errors + tb_errors;
    if (new_errors == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, new_errors);
      failed_tests++;
    end
    @(posedge clk);
  endtask

  // ====================
  // Lower-memory model
  // ====================
  always @(posedge clk) begin : mem_model
    line_t line;
    if (!rst_n) begin
      mem_res   <= '0;
      mem_phase = 0;
      mem_state = lcg_next(SEED);
    end else begin
      mem_res <= '0;
      case (mem_phase)
        0: begin
          if (mem_req.valid) begin
            mem_state = lcg_next(mem_state);
            mem_delay = 1 + int'(mem_state[17:16]);
            mem_phase = 1;
          end
        end
        1: begin
          mem_delay--;
          if (mem_delay == 0) begin
            if (mem_req.rw) begin
              mem_lines[mem_req.addr] = mem_req.wline;
              line = '0;
            end else if (mem_lines.exists(mem_req.addr)) begin
              line = mem_lines[mem_req.addr];
            end else begin
              line = fill_line(mem_req.addr);
            end
            mem_res   <= '{valid: 1'b1, rline: line};
            mem_phase = 2;
          end
        end
        // DUT takes the pulse here, its next request shows one edge later
        default: mem_phase = 0;
      endcase
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // ====================
  // Test sequence
  // ====================
  initial begin : main
    logic [31:0] rnd;
    logic [31:0] data;
    int          wb_before;
    int          line_no;
    cpu_req       = '0;
    rst_n         = 1'b0;
    stim_state    = SEED;
    tb_errors     = 0;
    errors_before = 0;
    failed_tests  = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    while (!cpu_ready) @(posedge clk);
    report_test(1, "reset sweep");
    for (int i = 0; i < N_COLD; i++) begin
      access(1'b0, window_addr(i, i % 4), '0);
    end
    report_test(2, "cold loads");
    // Line 1 hits, lines 8 to 10 miss on the store
    for (int i = 0; i < N_PAIR; i++) begin
      line_no = (i == 0) ? 1 : 7 + i;
      draw(data);
      access(1'b1, window_addr(line_no, i), data);
      access(1'b0, window_addr(line_no, i), '0);
    end
    report_test(3, "store then load");
    // Five tags in set 3, the last store must push out a dirty line
    wb_before = wb_count;
    for (int i = 0; i < N_EVICT; i++) begin
      draw(data);
      access(1'b1, window_addr(3 + 8 * i, i % 4), data);
    end
    for (int i = 0; i < N_EVICT; i++) begin
      access(1'b0, window_addr(3 + 8 * i, i % 4), '0);
    end
    if (wb_count == wb_before) begin
      $display("eviction test: no dirty line was written back");
      tb_errors++;
    end
    report_test(4, "dirty eviction");
    for (int i = 0; i < N_RAND; i++) begin
      draw(rnd);
      draw(data);
      access(((rnd >> 12) % 32'd100) < 32'd40, window_addr(int'(rnd % 32'd40),
             int'((rnd >> 8) % 32'd4)), data);
    end
    report_test(5, "random traffic");
    $display("tests: 5, failed: %0d, errors: %0d", failed_tests, errors + tb_errors);
    if (failed_tests == 0 && errors + tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache.f */
design/dcache_pkg.sv
design/dcache_ram.sv
design/dcache_plru.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_tb_clock.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal
PASS_TEXT ?= Simulation PASSED

RTL_SRCS := $(shell grep '^design/' $(FILELIST))
ALL_SRCS := $(shell grep '\.s\?v$$' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(ALL_SRCS)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
